/* hdl/io_pkg.sv */
package io_pkg;

    // Bus types
    typedef logic [15:1] io_addr_t;     // Word address, byte address bits 15..1
    typedef logic [15:0] io_data_t;
    typedef logic [1:0]  io_bytesel_t;  // Bit 0 low byte, bit 1 high byte
    typedef logic [2:0]  irq_vec_t;

    // I/O windows, byte addresses
    localparam logic [15:0] SYS_REGS_BASE = 16'hfffc;  // BIOS control, then LEDs
    localparam logic [15:0] IRQ_BASE      = 16'hfff4;  // Mask, then pending
    localparam logic [15:0] TIMER_ADDR    = 16'hffee;  // Reload value

    // Interrupt lines
    localparam int NUM_IRQ        = 8;
    localparam int TIMER_IRQ_LINE = 0;

    // Register values after reset
    localparam logic       BIOS_CTRL_RESET    = 1'b1;  // Boot from BIOS ROM
    localparam logic [7:0] LEDS_RESET         = 8'h00;
    localparam io_data_t   TIMER_RELOAD_RESET = 16'h0000;  // Timer stopped
    localparam logic [7:0] IRQ_MASK_RESET     = 8'h00;

endpackage

/* hdl/io_decoder.sv */
`timescale 1ns/1ps

module io_decoder (
    input  logic             clk,
    input  logic             rst,
    input  logic             io_access,
    input  io_pkg::io_addr_t io_addr,
    output logic             sys_cs,
    output logic             irq_cs,
    output logic             timer_cs,
    input  logic             sys_ack,
    input  logic             irq_ack,
    input  logic             timer_ack,
    input  io_pkg::io_data_t sys_rdata,
    input  io_pkg::io_data_t irq_rdata,
    input  io_pkg::io_data_t timer_rdata,
    output logic             io_ack,
    output io_pkg::io_data_t io_rdata
);
    import io_pkg::*;

    logic [15:0] byte_addr;
    logic        sys_hit;
    logic        irq_hit;
    logic        timer_hit;
    logic        default_sel;
    logic        default_sel_q;
    logic        default_ack;

    assign byte_addr = {io_addr, 1'b0};

    // Two-word windows ignore address bit 1
    assign sys_hit   = ({byte_addr[15:2], 2'b00} == SYS_REGS_BASE);
    assign irq_hit   = ({byte_addr[15:2], 2'b00} == IRQ_BASE);
    assign timer_hit = (byte_addr == TIMER_ADDR);

    assign sys_cs   = io_access & sys_hit;
    assign irq_cs   = io_access & irq_hit;
    assign timer_cs = io_access & timer_hit;

    // Nobody claims the address
    assign default_sel = io_access & ~(sys_hit | irq_hit | timer_hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            default_sel_q <= 1'b0;
            default_ack   <= 1'b0;
        end else begin
            default_sel_q <= default_sel;
            default_ack   <= default_sel & ~default_sel_q;  // Once per access
        end
    end

    // Wired-OR return path, idle blocks drive zero
    assign io_ack   = sys_ack | irq_ack | timer_ack | default_ack;
    assign io_rdata = sys_rdata | irq_rdata | timer_rdata;

endmodule

/* hdl/sys_regs.sv */
`timescale 1ns/1ps

module sys_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cs,
    input  logic                reg_sel,
    input  logic                wr_en,
    input  io_pkg::io_bytesel_t bytesel,
    input  io_pkg::io_data_t    wdata,
    output logic                ack,
    output io_pkg::io_data_t    rdata,
    output logic [7:0]          leds,
    output logic                bios_enabled
);
    import io_pkg::*;

    logic cs_q;
    logic start;

    assign start = cs & ~cs_q;  // First cycle of the access

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q         <= 1'b0;
            ack          <= 1'b0;
            rdata        <= '0;
            leds         <= LEDS_RESET;
            bios_enabled <= BIOS_CTRL_RESET;
        end else begin
            cs_q  <= cs;
            ack   <= start;
            rdata <= '0;

            if (start && !wr_en) begin
                if (reg_sel)
                    rdata <= {8'h00, leds};
                else
                    rdata <= {{15{1'b0}}, bios_enabled};
            end

            // Both registers live in the low byte
            if (start && wr_en && bytesel[0]) begin
                if (reg_sel)
                    leds <= wdata[7:0];
                else
                    bios_enabled <= wdata[0];
            end
        end
    end

endmodule

/* hdl/interval_timer.sv */
`timescale 1ns/1ps

module interval_timer #(
    parameter int TICK_DIV = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cs,
    input  logic                wr_en,
    input  io_pkg::io_bytesel_t bytesel,
    input  io_pkg::io_data_t    wdata,
    output logic                ack,
    output io_pkg::io_data_t    rdata,
    output logic                timer_intr
);
    import io_pkg::*;

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

    logic             cs_q;
    logic             start;
    logic             load;
    io_data_t         reload;
    io_data_t         reload_next;
    io_data_t         count;
    logic [DIV_W-1:0] div_cnt;
    logic             running;
    logic             tick;

    assign start = cs & ~cs_q;
    assign load  = start & wr_en;

    // Byte-lane merge of the new reload value
    assign reload_next = {bytesel[1] ? wdata[15:8] : reload[15:8],
                          bytesel[0] ? wdata[7:0]  : reload[7:0]};

    assign running = (reload != '0);  // Zero reload stops the timer
    assign tick    = running && (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q  <= 1'b0;
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            cs_q  <= cs;
            ack   <= start;
            rdata <= (start && !wr_en) ? reload : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reload     <= TIMER_RELOAD_RESET;
            count      <= TIMER_RELOAD_RESET;
            div_cnt    <= '0;
            timer_intr <= 1'b0;
        end else begin
            timer_intr <= 1'b0;

            if (load) begin
                reload  <= reload_next;
                count   <= reload_next;
                div_cnt <= '0;  // Restart prescaler
            end else if (running) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;

                if (tick) begin
                    if (count <= 16'd1) begin
                        count      <= reload;
                        timer_intr <= 1'b1;  // Expired
                    end else begin
                        count <= count - 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hdl/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cs,
    input  logic                       reg_sel,
    input  logic                       wr_en,
    input  io_pkg::io_bytesel_t        bytesel,
    input  io_pkg::io_data_t           wdata,
    output logic                       ack,
    output io_pkg::io_data_t           rdata,
    input  logic [io_pkg::NUM_IRQ-1:0] irq_in,
    output logic                       intr,
    output io_pkg::irq_vec_t           irq_vector
);
    import io_pkg::*;

    logic               cs_q;
    logic               start;
    logic               wr_lo;
    logic [NUM_IRQ-1:0] mask;
    logic [NUM_IRQ-1:0] pending;
    logic [NUM_IRQ-1:0] clear;
    logic [NUM_IRQ-1:0] active;
    irq_vec_t           lowest;

    assign start = cs & ~cs_q;
    assign wr_lo = start & wr_en & bytesel[0];

    // Write-one-to-clear on the pending register
    assign clear = (wr_lo && reg_sel) ? wdata[NUM_IRQ-1:0] : '0;

    assign active = pending & mask;

    // Lowest index has the highest priority
    always_comb begin
        lowest = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (active[i])
                lowest = irq_vec_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q       <= 1'b0;
            ack        <= 1'b0;
            rdata      <= '0;
            mask       <= IRQ_MASK_RESET;
            pending    <= '0;
            intr       <= 1'b0;
            irq_vector <= '0;
        end else begin
            cs_q  <= cs;
            ack   <= start;
            rdata <= '0;
            if (start && !wr_en)
                rdata <= reg_sel ? io_data_t'(pending) : io_data_t'(mask);

            if (wr_lo && !reg_sel)
                mask <= wdata[NUM_IRQ-1:0];

            pending <= (pending & ~clear) | irq_in;  // New request beats a clear

            intr       <= |active;
            irq_vector <= lowest;
        end
    end

endmodule

/* hdl/io_subsystem.sv */
`timescale 1ns/1ps

module io_subsystem #(
    parameter int TICK_DIV = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       io_access,
    input  logic                       io_wr_en,
    input  io_pkg::io_addr_t           io_addr,
    input  io_pkg::io_bytesel_t        io_bytesel,
    input  io_pkg::io_data_t           io_wdata,
    output logic                       io_ack,
    output io_pkg::io_data_t           io_rdata,
    input  logic [io_pkg::NUM_IRQ-2:0] ext_irq,
    output logic [7:0]                 leds,
    output logic                       bios_enabled,
    output logic                       intr,
    output io_pkg::irq_vec_t           irq_vector
);
    import io_pkg::*;

    localparam logic [NUM_IRQ-1:0] TIMER_BIT = NUM_IRQ'(1) << TIMER_IRQ_LINE;
    localparam logic [NUM_IRQ-1:0] LOW_LINES = TIMER_BIT - 1'b1;

    logic               sys_cs;
    logic               irq_cs;
    logic               timer_cs;
    logic               sys_ack;
    logic               irq_ack;
    logic               timer_ack;
    io_data_t           sys_rdata;
    io_data_t           irq_rdata;
    io_data_t           timer_rdata;
    logic               timer_intr;
    logic [NUM_IRQ-1:0] ext_lines;
    logic [NUM_IRQ-1:0] irq_lines;

    // External lines fill every slot except the timer's
    assign ext_lines = {1'b0, ext_irq};
    assign irq_lines = (ext_lines & LOW_LINES)
                     | ((ext_lines << 1) & ~(LOW_LINES | TIMER_BIT))
                     | (timer_intr ? TIMER_BIT : '0);

    io_decoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .io_access   (io_access),
        .io_addr     (io_addr),
        .sys_cs      (sys_cs),
        .irq_cs      (irq_cs),
        .timer_cs    (timer_cs),
        .sys_ack     (sys_ack),
        .irq_ack     (irq_ack),
        .timer_ack   (timer_ack),
        .sys_rdata   (sys_rdata),
        .irq_rdata   (irq_rdata),
        .timer_rdata (timer_rdata),
        .io_ack      (io_ack),
        .io_rdata    (io_rdata)
    );

    sys_regs sys_regs_i (
        .clk          (clk),
        .rst          (rst),
        .cs           (sys_cs),
        .reg_sel      (io_addr[1]),
        .wr_en        (io_wr_en),
        .bytesel      (io_bytesel),
        .wdata        (io_wdata),
        .ack          (sys_ack),
        .rdata        (sys_rdata),
        .leds         (leds),
        .bios_enabled (bios_enabled)
    );

    interval_timer #(
        .TICK_DIV (TICK_DIV)
    ) timer_i (
        .clk        (clk),
        .rst        (rst),
        .cs         (timer_cs),
        .wr_en      (io_wr_en),
        .bytesel    (io_bytesel),
        .wdata      (io_wdata),
        .ack        (timer_ack),
        .rdata      (timer_rdata),
        .timer_intr (timer_intr)
    );

    irq_controller irq_i (
        .clk        (clk),
        .rst        (rst),
        .cs         (irq_cs),
        .reg_sel    (io_addr[1]),
        .wr_en      (io_wr_en),
        .bytesel    (io_bytesel),
        .wdata      (io_wdata),
        .ack        (irq_ack),
        .rdata      (irq_rdata),
        .irq_in     (irq_lines),
        .intr       (intr),
        .irq_vector (irq_vector)
    );

endmodule

/* dv/io_tb.sv */
`timescale 1ns/1ps

module io_tb;
    import io_pkg::*;

    parameter int TICK_DIV = 4;

    localparam int RESET_CYCLES  = 8;
    localparam int ACK_LATENCY   = 1;   // Falling edges from io_access to io_ack
    localparam int ACK_TIMEOUT   = 16;
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_RW        = 60;
    localparam int NUM_IRQ_STEPS = 40;
    localparam int MAX_RELOAD    = 20;
    localparam int TIMER_RISES   = 4;
    localparam int RISE_TIMEOUT  = 2 * MAX_RELOAD * TICK_DIV + 20;
    localparam int PLANNED_XFERS = 8 + NUM_RANDOM + 2 * NUM_RW + 12 + 3 * NUM_IRQ_STEPS;
    localparam int TIMER_WINDOWS = (TIMER_RISES + 3) * MAX_RELOAD * TICK_DIV;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 10 * PLANNED_XFERS + TIMER_WINDOWS;

    localparam logic [15:0] A_BIOS  = SYS_REGS_BASE;
    localparam logic [15:0] A_LEDS  = SYS_REGS_BASE + 16'd2;
    localparam logic [15:0] A_MASK  = IRQ_BASE;
    localparam logic [15:0] A_PEND  = IRQ_BASE + 16'd2;
    localparam logic [15:0] A_TIMER = TIMER_ADDR;

    logic               clk = 1'b0;
    logic               rst;
    logic               io_access;
    logic               io_wr_en;
    io_addr_t           io_addr;
    io_bytesel_t        io_bytesel;
    io_data_t           io_wdata;
    logic               io_ack;
    io_data_t           io_rdata;
    logic [NUM_IRQ-2:0] ext_irq;
    logic [7:0]         leds;
    logic               bios_enabled;
    logic               intr;
    irq_vec_t           irq_vector;

    // Reference model state
    logic [7:0] m_leds    = 8'h00;
    logic       m_bios    = 1'b1;
    io_data_t   m_reload  = 16'h0000;
    logic [7:0] m_mask    = 8'h00;
    logic [7:0] m_pending = 8'h00;

    int    checks = 0;
    int    errors = 0;
    int    cycle  = 0;
    int    rise_q[$];
    logic  intr_seen = 1'b0;
    string test_name;
    int    test_checks;
    int    test_errors;

    io_subsystem #(
        .TICK_DIV (TICK_DIV)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .io_access    (io_access),
        .io_wr_en     (io_wr_en),
        .io_addr      (io_addr),
        .io_bytesel   (io_bytesel),
        .io_wdata     (io_wdata),
        .io_ack       (io_ack),
        .io_rdata     (io_rdata),
        .ext_irq      (ext_irq),
        .leds         (leds),
        .bios_enabled (bios_enabled),
        .intr         (intr),
        .irq_vector   (irq_vector)
    );

    always #10 clk = ~clk;

    // Cycle stamps of intr rising edges
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (intr && !intr_seen)
            rise_q.push_back(cycle);
        intr_seen = intr;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_data(input string what, input io_data_t got, input io_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vec(input string what, input irq_vec_t got, input irq_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("test %-14s %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    function automatic io_data_t expected_read(input logic [15:0] addr);
        case (addr)
            A_BIOS:  return {15'h0000, m_bios};
            A_LEDS:  return {8'h00, m_leds};
            A_MASK:  return {8'h00, m_mask};
            A_PEND:  return {8'h00, m_pending};
            A_TIMER: return m_reload;
            default: return 16'h0000;  // Unmapped
        endcase
    endfunction

    task automatic apply_write(input logic [15:0] addr, input io_bytesel_t be,
                               input io_data_t data);
        case (addr)
            A_BIOS:  if (be[0]) m_bios = data[0];
            A_LEDS:  if (be[0]) m_leds = data[7:0];
            A_MASK:  if (be[0]) m_mask = data[7:0];
            A_PEND:  if (be[0]) m_pending = m_pending & ~data[7:0];
            A_TIMER: begin
                if (be[0]) m_reload[7:0] = data[7:0];
                if (be[1]) m_reload[15:8] = data[15:8];
            end
            default: ;
        endcase
    endtask

    function automatic irq_vec_t first_active(input logic [7:0] act);
        irq_vec_t vec;
        logic     found;
        vec   = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (act[i] && !found) begin
                vec   = irq_vec_t'(i);
                found = 1'b1;
            end
        end
        return vec;
    endfunction

    // Starts and ends on a falling edge
    task automatic bus_xfer(input logic wr, input logic [15:0] addr, input io_bytesel_t be,
                            input io_data_t wdata, output io_data_t rdata);
        int   waited;
        logic got_ack;
        io_addr    <= addr[15:1];
        io_wr_en   <= wr;
        io_bytesel <= be;
        io_wdata   <= wdata;
        io_access  <= 1'b1;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
            got_ack = io_ack;
        end
        rdata = io_rdata;
        checks++;
        if (!got_ack) begin
            errors++;
            $display("no acknowledge from address %h within %0d cycles", addr, ACK_TIMEOUT);
        end else if (waited != ACK_LATENCY) begin
            errors++;
            $display("error at %0t: ack from %h after %0d cycles, expected %0d",
                     $time, addr, waited, ACK_LATENCY);
        end
        @(negedge clk);
        check_bit($sformatf("repeated ack from %h", addr), io_ack, 1'b0);
        io_access <= 1'b0;
        io_wr_en  <= 1'b0;
        if (wr && got_ack)
            apply_write(addr, be, wdata);
        @(negedge clk);  // Idle cycle between transfers
    endtask

    task automatic write_reg(input logic [15:0] addr, input io_bytesel_t be, input io_data_t data);
        io_data_t unused;
        bus_xfer(1'b1, addr, be, data, unused);
    endtask

    task automatic read_reg(input logic [15:0] addr, output io_data_t data);
        bus_xfer(1'b0, addr, 2'b11, 16'h0000, data);
    endtask

    function automatic logic [15:0] random_addr();
        case ($urandom % 8)
            0:       return A_BIOS;
            1:       return A_LEDS;
            2:       return A_MASK;
            3:       return A_PEND;
            4:       return A_TIMER;
            5:       return 16'hfff0 | (16'($urandom) & 16'h000e);  // Near the windows
            default: return 16'($urandom) & 16'hfffe;
        endcase
    endfunction

    task automatic check_irq_pins(input string what);
        logic [7:0] act;
        act = m_pending & m_mask;
        check_bit({what, " intr"}, intr, |act);
        if (|act)
            check_vec({what, " vector"}, irq_vector, first_active(act));
    endtask

    task automatic wait_rise(input int count);
        int waited;
        waited = 0;
        while (rise_q.size() < count && waited < RISE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rise_q.size() < count) begin
            checks++;
            errors++;
            $display("timer interrupt %0d did not arrive within %0d cycles", count, RISE_TIMEOUT);
        end
    endtask

    initial begin
        io_data_t    rd;
        logic [15:0] addr;
        int          reload;
        logic [6:0]  pat;

        void'($urandom(32'h1c2fe32b));
        rst        <= 1'b1;
        io_access  <= 1'b0;
        io_wr_en   <= 1'b0;
        io_addr    <= '0;
        io_bytesel <= '0;
        io_wdata   <= '0;
        ext_irq    <= '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst <= 1'b0;
        @(negedge clk);

        begin_test("reset_state");
        check_data("leds pin", {8'h00, leds}, 16'h0000);
        check_bit("bios_enabled pin", bios_enabled, 1'b1);
        check_bit("intr pin", intr, 1'b0);
        read_reg(A_BIOS, rd);
        check_data("bios control", rd, 16'h0001);
        read_reg(A_LEDS, rd);
        check_data("led register", rd, 16'h0000);
        read_reg(A_MASK, rd);
        check_data("mask register", rd, 16'h0000);
        read_reg(A_PEND, rd);
        check_data("pending register", rd, 16'h0000);
        read_reg(A_TIMER, rd);
        check_data("timer reload", rd, 16'h0000);
        end_test();

        begin_test("random_bus");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            addr = random_addr();
            if ($urandom % 2 == 0) begin
                write_reg(addr, io_bytesel_t'($urandom), io_data_t'($urandom));
            end else begin
                read_reg(addr, rd);
                if (addr != A_PEND)  // Timer may set pending bits
                    check_data($sformatf("read %h", addr), rd, expected_read(addr));
            end
        end
        check_data("leds pin", {8'h00, leds}, {8'h00, m_leds});
        check_bit("bios_enabled pin", bios_enabled, m_bios);
        end_test();

        begin_test("reg_readback");
        for (int n = 0; n < NUM_RW; n++) begin
            case ($urandom % 4)
                0:       addr = A_LEDS;
                1:       addr = A_BIOS;
                2:       addr = A_TIMER;
                default: addr = A_MASK;
            endcase
            write_reg(addr, io_bytesel_t'($urandom), io_data_t'($urandom));
            read_reg(addr, rd);
            check_data($sformatf("read back %h", addr), rd, expected_read(addr));
            check_data("leds pin", {8'h00, leds}, {8'h00, m_leds});
            check_bit("bios_enabled pin", bios_enabled, m_bios);
        end
        end_test();

        begin_test("timer_period");
        write_reg(A_TIMER, 2'b11, 16'h0000);
        write_reg(A_PEND, 2'b01, 16'h00ff);
        write_reg(A_MASK, 2'b01, 16'h0001 << TIMER_IRQ_LINE);
        repeat (3) @(negedge clk);
        rise_q.delete();
        reload = 1 + int'($urandom % MAX_RELOAD);
        if (reload * TICK_DIV < 4)
            reload = 4;  // Leaves room for the pending clear
        write_reg(A_TIMER, 2'b11, io_data_t'(reload));
        for (int k = 0; k < TIMER_RISES; k++) begin
            wait_rise(k + 1);
            check_vec("timer vector", irq_vector, irq_vec_t'(TIMER_IRQ_LINE));
            m_pending[TIMER_IRQ_LINE] = 1'b1;
            write_reg(A_PEND, 2'b01, 16'h0001 << TIMER_IRQ_LINE);
        end
        for (int k = 1; k < rise_q.size() && k < TIMER_RISES; k++)
            check_count("timer period", rise_q[k] - rise_q[k - 1], reload * TICK_DIV);
        write_reg(A_TIMER, 2'b11, 16'h0000);
        write_reg(A_PEND, 2'b01, 16'h00ff);
        rise_q.delete();
        repeat (2 * MAX_RELOAD * TICK_DIV) @(negedge clk);
        check_count("interrupts after stop", rise_q.size(), 0);
        check_bit("intr after stop", intr, 1'b0);
        end_test();

        begin_test("irq_priority");
        write_reg(A_MASK, 2'b01, io_data_t'($urandom) & 16'h00ff);
        for (int n = 0; n < NUM_IRQ_STEPS; n++) begin
            pat = 7'($urandom) & 7'($urandom);  // Sparse requests
            ext_irq <= pat;
            @(negedge clk);
            ext_irq <= '0;
            m_pending = m_pending | {pat, 1'b0};
            @(negedge clk);
            check_irq_pins("after request");
            read_reg(A_PEND, rd);
            check_data("pending register", rd, {8'h00, m_pending});
            case ($urandom % 4)
                0: begin
                    write_reg(A_PEND, 2'b01, io_data_t'($urandom) & 16'h00ff);
                    check_irq_pins("after clear");
                    read_reg(A_PEND, rd);
                    check_data("pending after clear", rd, {8'h00, m_pending});
                end
                1: begin
                    write_reg(A_MASK, 2'b01, io_data_t'($urandom) & 16'h00ff);
                    check_irq_pins("after mask");
                end
                default: ;
            endcase
        end
        end_test();

        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/io_pkg.sv
hdl/io_decoder.sv
hdl/sys_regs.sv
hdl/interval_timer.sv
hdl/irq_controller.sv
hdl/io_subsystem.sv
dv/io_tb.sv

/* Makefile */
# Verilator build and run for the I/O subsystem testbench

VERILATOR ?= verilator
TOP       ?= io_tb
TICK_DIV  ?= 4
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP TICK_DIV BUILD_DIR LOG FILELIST VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GTICK_DIV=$(TICK_DIV) \
	    --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation PASSED" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
